/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module breaker_tb -f breaker_top.f

run: compile
	@out=$$(./obj_dir/Vbreaker_tb); echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir

/* breaker_top.f */
common/breaker_pkg.sv
design/game_ctrl.sv
design/pixel_arbiter.sv
design/screen_wiper.sv
design/rect_painter.sv
bricks/brick_table.sv
bricks/brick_scan.sv
design/ball_mover.sv
design/breaker_top.sv
sim/breaker_sva.sv
sim/breaker_tb.sv

/* bricks/brick_scan.sv */
`default_nettype none

module brick_scan
	import breaker_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       scan_req,
	input  logic       scan_hit_mode,
	output logic       scan_ack,
	output logic       hit,
	input  ball_t      ball,
	output brick_idx_t rd_idx,
	input  brick_t     rd_data,
	output logic       clr,
	output brick_idx_t clr_idx,
	output logic       bus_req,
	input  logic       bus_gnt,
	output pixel_t     pix,
	output logic       pix_valid
);

	typedef enum logic [2:0] {
		SC_IDLE,
		SC_READ,
		SC_CHECK,
		SC_PAINT,
		SC_ACK
	} scan_state_t;

	scan_state_t state;
	brick_idx_t  idx;
	logic [5:0]  cnt;
	logic        mode;      // 1 looks for a hit, 0 draws everything
	logic        live, overlap, take, last_idx;

	assign live = rd_data.colour != '0;
	assign overlap = (ball.x + x_t'(BALL_SIZE - 1) >= rd_data.x)
		&& (ball.x <= rd_data.x + x_t'(BRICK_W - 1))
		&& (ball.y + y_t'(BALL_SIZE - 1) >= rd_data.y)
		&& (ball.y <= rd_data.y + y_t'(BRICK_H - 1));
	assign take = live && (!mode || overlap);
	assign last_idx = idx == brick_idx_t'(BRICK_COUNT - 1);

	assign rd_idx = idx;     // held steady, so rd_data keeps the brick while painting
	assign clr_idx = idx;
	assign bus_req = state inside {SC_READ, SC_CHECK, SC_PAINT};

	assign pix.x = rd_data.x + x_t'(cnt[3:0]);
	assign pix.y = rd_data.y + y_t'(cnt[5:4]);
	assign pix.colour = mode ? '0 : rd_data.colour;
	assign pix_valid = (state == SC_PAINT) && bus_gnt;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state <= SC_IDLE;
			scan_ack <= 1'b0;
			hit <= 1'b0;
			clr <= 1'b0;
		end
		else
		begin
			clr <= 1'b0;
			case (state)
				SC_IDLE:
				begin
					if (scan_req && !scan_ack)
					begin
						idx <= '0;
						mode <= scan_hit_mode;
						hit <= 1'b0;
						state <= SC_READ;
					end
				end
				SC_READ: state <= SC_CHECK;   // one cycle table latency
				SC_CHECK:
				begin
					if (take)
					begin
						cnt <= '0;
						clr <= mode;
						hit <= mode;
						state <= SC_PAINT;
					end
					else if (last_idx)
					begin
						scan_ack <= 1'b1;
						state <= SC_ACK;
					end
					else
					begin
						idx <= idx + 1'b1;
						state <= SC_READ;
					end
				end
				SC_PAINT:
				begin
					if (bus_gnt)
					begin
						cnt <= cnt + 1'b1;
						if (cnt == 6'(BRICK_W * BRICK_H - 1))
						begin
							if (mode || last_idx)   // only the first hit counts
							begin
								scan_ack <= 1'b1;
								state <= SC_ACK;
							end
							else
							begin
								idx <= idx + 1'b1;
								state <= SC_READ;
							end
						end
					end
				end
				SC_ACK:
				begin
					if (!scan_req)
					begin
						scan_ack <= 1'b0;
						state <= SC_IDLE;
					end
				end
				default: state <= SC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* bricks/brick_table.sv */
`default_nettype none

module brick_table
	import breaker_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  brick_idx_t rd_idx,
	output brick_t     rd_data,
	input  logic       clr,
	input  brick_idx_t clr_idx
);

	brick_t     mem [64];
	brick_t     fill_entry;
	logic       filling;
	brick_idx_t fill_idx;
	logic [3:0] col;
	logic [2:0] row;
	colour_t    shade;       // (i mod 7) + 1

	// slots past the last brick stay cleared
	assign fill_entry = (fill_idx < BRICK_COUNT) ?
		'{x: x_t'(col * BRICK_PITCH_X), y: y_t'(row * BRICK_PITCH_Y), colour: shade} : '0;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			filling <= 1'b1;
			fill_idx <= '0;
			col <= '0;
			row <= '0;
			shade <= colour_t'(1);
		end
		else if (filling)
		begin
			filling <= fill_idx != '1;
			fill_idx <= fill_idx + 1'b1;
			shade <= (shade == colour_t'(7)) ? colour_t'(1) : shade + 1'b1;
			if (col == 4'(BRICK_COLS - 1))
			begin
				col <= '0;
				row <= row + 1'b1;
			end
			else
				col <= col + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (filling)
			mem[fill_idx] <= fill_entry;
		else if (clr)
			mem[clr_idx].colour <= '0;   // black marks a hit brick
		rd_data <= mem[rd_idx];
	end

endmodule

`default_nettype wire

/* common/breaker_pkg.sv */
`default_nettype none

package breaker_pkg;

	typedef logic [7:0] x_t;
	typedef logic [6:0] y_t;
	typedef logic [2:0] colour_t;     // 0 is black, also marks a cleared brick
	typedef logic [5:0] brick_idx_t;

	typedef struct packed {
		x_t      x;
		y_t      y;
		colour_t colour;
	} pixel_t;

	typedef struct packed {
		x_t      x;
		y_t      y;
		colour_t colour;
	} brick_t;

	typedef struct packed {
		x_t      x;
		y_t      y;
		logic    is_ball;   // 0 paddle 16x4, 1 ball 2x2
		colour_t colour;
	} rect_job_t;

	typedef struct packed {
		x_t   x;
		y_t   y;
		logic dx;           // 1 moves right
		logic dy;           // 1 moves down
	} ball_t;

	typedef enum logic [3:0] {
		ST_WIPE,
		ST_BRICKS,
		ST_PAD_DRAW,
		ST_WAIT,
		ST_PAD_ERASE,
		ST_PAD_MOVE,
		ST_BALL_ERASE,
		ST_SCAN,
		ST_DEFLECT,
		ST_BALL_MOVE,
		ST_BALL_DRAW
	} ctrl_state_t;

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	localparam int BRICK_W = 16;
	localparam int BRICK_H = 4;
	localparam int BRICK_COLS = 10;
	localparam int BRICK_ROWS = 4;
	localparam int BRICK_COUNT = BRICK_COLS * BRICK_ROWS;
	localparam int BRICK_PITCH_X = 16;
	localparam int BRICK_PITCH_Y = 8;

	localparam int PADDLE_W = 16;
	localparam int PADDLE_H = 4;
	localparam int PADDLE_Y = 115;
	localparam int PADDLE_MAX_X = SCREEN_W - PADDLE_W;
	localparam int BALL_SIZE = 2;

	localparam int PADDLE_START_X = 80;
	localparam int BALL_START_X = 88;
	localparam int BALL_START_Y = 98;
	localparam int BALL_TURN_Y = 110;    // row where the paddle is tested
	localparam int BALL_FLOOR_Y = 117;

	localparam colour_t PADDLE_COLOUR = 3'd7;
	localparam colour_t BALL_COLOUR = 3'd4;

	localparam int FRAME_CYCLES = 833334;   // 60 Hz at 50 MHz
	localparam int TIMER_W = 20;
	localparam int PADDLE_FRAMES = 3;
	localparam int BALL_FRAMES = 2;

endpackage

`default_nettype wire

/* design/ball_mover.sv */
`default_nettype none

module ball_mover
	import breaker_pkg::*;
(
	input  logic  clk,
	input  logic  resetn,
	input  logic  move,
	input  logic  deflect,
	input  x_t    paddle_x,
	output ball_t ball
);

	logic [8:0] rel;
	logic       on_paddle;

	// negative offset shows up in bit 8
	assign rel = {1'b0, ball.x} - {1'b0, paddle_x};
	assign on_paddle = !rel[8] && (rel[7:0] < PADDLE_W);

	always_ff @(posedge clk)
	begin
		if (!resetn)
			ball <= '{x: x_t'(BALL_START_X), y: y_t'(BALL_START_Y), dx: 1'b1, dy: 1'b0};
		else if (deflect)
			ball.dy <= ~ball.dy;
		else if (move)
		begin
			if (ball.dx)
			begin
				if (ball.x == x_t'(SCREEN_W - BALL_SIZE))   // right wall
				begin
					ball.x <= x_t'(SCREEN_W - BALL_SIZE - 1);
					ball.dx <= 1'b0;
				end
				else
					ball.x <= ball.x + 1'b1;
			end
			else if (ball.x == '0)
			begin
				ball.x <= x_t'(1);
				ball.dx <= 1'b1;
			end
			else
				ball.x <= ball.x - 1'b1;

			if (ball.dy)
			begin
				if (ball.y == y_t'(BALL_TURN_Y) && on_paddle)
				begin
					ball.y <= y_t'(BALL_TURN_Y - 1);
					ball.dy <= 1'b0;
				end
				else if (ball.y == y_t'(BALL_FLOOR_Y))   // bottom wall bounces too
				begin
					ball.y <= y_t'(BALL_FLOOR_Y - 1);
					ball.dy <= 1'b0;
				end
				else
					ball.y <= ball.y + 1'b1;
			end
			else if (ball.y == '0)
			begin
				ball.y <= y_t'(1);
				ball.dy <= 1'b1;
			end
			else
				ball.y <= ball.y - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/breaker_top.sv */
`default_nettype none

module breaker_top
	import breaker_pkg::*;
#(
	parameter int frame_cycles = FRAME_CYCLES
)
(
	input  logic   clk,
	input  logic   resetn,
	input  x_t     paddle_pos,
	output pixel_t pixel,
	output logic   plot
);

	// bus slots: 0 wiper, 1 brick scanner, 2 rect painter
	logic [2:0]   bus_req;
	logic [2:0]   bus_gnt;
	logic [2:0]   bus_valid;
	pixel_t [2:0] bus_pix;

	logic       wipe_req, wipe_ack;
	logic       job_req, job_ack;
	rect_job_t  job;
	logic       scan_req, scan_hit_mode, scan_ack, hit;
	logic       move, deflect;
	x_t         paddle_x;
	ball_t      ball;
	brick_idx_t rd_idx, clr_idx;
	brick_t     rd_data;
	logic       clr;

	game_ctrl #(
		.frame_cycles(frame_cycles)
	) u_ctrl (
		.clk(clk),
		.resetn(resetn),
		.paddle_pos(paddle_pos),
		.ball(ball),
		.wipe_req(wipe_req),
		.wipe_ack(wipe_ack),
		.job_req(job_req),
		.job(job),
		.job_ack(job_ack),
		.scan_req(scan_req),
		.scan_hit_mode(scan_hit_mode),
		.scan_ack(scan_ack),
		.hit(hit),
		.move(move),
		.deflect(deflect),
		.paddle_x(paddle_x)
	);

	pixel_arbiter u_arb (
		.clk(clk),
		.resetn(resetn),
		.bus_req(bus_req),
		.bus_gnt(bus_gnt),
		.pix(bus_pix),
		.pix_valid(bus_valid),
		.pixel(pixel),
		.plot(plot)
	);

	screen_wiper u_wiper (
		.clk(clk),
		.resetn(resetn),
		.wipe_req(wipe_req),
		.wipe_ack(wipe_ack),
		.bus_req(bus_req[0]),
		.bus_gnt(bus_gnt[0]),
		.pix(bus_pix[0]),
		.pix_valid(bus_valid[0])
	);

	brick_scan u_scan (
		.clk(clk),
		.resetn(resetn),
		.scan_req(scan_req),
		.scan_hit_mode(scan_hit_mode),
		.scan_ack(scan_ack),
		.hit(hit),
		.ball(ball),
		.rd_idx(rd_idx),
		.rd_data(rd_data),
		.clr(clr),
		.clr_idx(clr_idx),
		.bus_req(bus_req[1]),
		.bus_gnt(bus_gnt[1]),
		.pix(bus_pix[1]),
		.pix_valid(bus_valid[1])
	);

	rect_painter u_rect (
		.clk(clk),
		.resetn(resetn),
		.job_req(job_req),
		.job(job),
		.job_ack(job_ack),
		.bus_req(bus_req[2]),
		.bus_gnt(bus_gnt[2]),
		.pix(bus_pix[2]),
		.pix_valid(bus_valid[2])
	);

	brick_table u_table (
		.clk(clk),
		.resetn(resetn),
		.rd_idx(rd_idx),
		.rd_data(rd_data),
		.clr(clr),
		.clr_idx(clr_idx)
	);

	ball_mover u_ball (
		.clk(clk),
		.resetn(resetn),
		.move(move),
		.deflect(deflect),
		.paddle_x(paddle_x),
		.ball(ball)
	);

endmodule

`default_nettype wire

/* design/game_ctrl.sv */
`default_nettype none

module game_ctrl
	import breaker_pkg::*;
#(
	parameter int frame_cycles = FRAME_CYCLES
)
(
	input  logic      clk,
	input  logic      resetn,
	input  x_t        paddle_pos,
	input  ball_t     ball,
	output logic      wipe_req,
	input  logic      wipe_ack,
	output logic      job_req,
	output rect_job_t job,
	input  logic      job_ack,
	output logic      scan_req,
	output logic      scan_hit_mode,
	input  logic      scan_ack,
	input  logic      hit,
	output logic      move,
	output logic      deflect,
	output x_t        paddle_x
);

	ctrl_state_t        state;
	logic [TIMER_W-1:0] timer;
	logic [1:0]         pad_frames, ball_frames;
	logic               frame_tick, pad_due, ball_due, take_pad, take_ball;
	logic               rect_state, ball_job, erase_job;
	logic               wipe_done, job_done, scan_done;

	assign frame_tick = timer == TIMER_W'(frame_cycles - 1);
	assign pad_due = pad_frames == PADDLE_FRAMES;
	assign ball_due = ball_frames == BALL_FRAMES;
	assign take_pad = (state == ST_WAIT) && pad_due;   // paddle wins a tie
	assign take_ball = (state == ST_WAIT) && !pad_due && ball_due;

	assign wipe_done = wipe_req && wipe_ack;
	assign job_done = job_req && job_ack;
	assign scan_done = scan_req && scan_ack;

	assign rect_state = state inside {ST_PAD_DRAW, ST_PAD_ERASE, ST_BALL_ERASE, ST_BALL_DRAW};
	assign ball_job = state inside {ST_BALL_ERASE, ST_BALL_DRAW};
	assign erase_job = state inside {ST_PAD_ERASE, ST_BALL_ERASE};

	assign job.x = ball_job ? ball.x : paddle_x;
	assign job.y = ball_job ? ball.y : y_t'(PADDLE_Y);
	assign job.is_ball = ball_job;
	assign job.colour = erase_job ? '0 : (ball_job ? BALL_COLOUR : PADDLE_COLOUR);

	assign move = state == ST_BALL_MOVE;
	assign deflect = state == ST_DEFLECT;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			timer <= '0;
			pad_frames <= '0;
			ball_frames <= '0;
		end
		else
		begin
			timer <= frame_tick ? '0 : timer + 1'b1;
			if (take_pad)
				pad_frames <= '0;
			else if (frame_tick && !pad_due)
				pad_frames <= pad_frames + 1'b1;
			if (take_ball)
				ball_frames <= '0;
			else if (frame_tick && !ball_due)
				ball_frames <= ball_frames + 1'b1;
		end
	end

	// req rises only once the unit has dropped its previous ack
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			wipe_req <= 1'b0;
			job_req <= 1'b0;
			scan_req <= 1'b0;
			scan_hit_mode <= 1'b0;
		end
		else
		begin
			if (wipe_done)
				wipe_req <= 1'b0;
			else if (state == ST_WIPE && !wipe_ack)
				wipe_req <= 1'b1;
			if (job_done)
				job_req <= 1'b0;
			else if (rect_state && !job_ack)
				job_req <= 1'b1;
			if (scan_done)
				scan_req <= 1'b0;
			else if (state inside {ST_BRICKS, ST_SCAN} && !scan_ack && !scan_req)
			begin
				scan_req <= 1'b1;
				scan_hit_mode <= state == ST_SCAN;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state <= ST_WIPE;
			paddle_x <= x_t'(PADDLE_START_X);
		end
		else
		begin
			case (state)
				ST_WIPE:       if (wipe_done) state <= ST_BRICKS;
				ST_BRICKS:     if (scan_done) state <= ST_PAD_DRAW;
				ST_PAD_DRAW:   if (job_done) state <= ST_WAIT;
				ST_WAIT:
				begin
					if (take_pad)
						state <= ST_PAD_ERASE;
					else if (take_ball)
						state <= ST_BALL_ERASE;
				end
				ST_PAD_ERASE:  if (job_done) state <= ST_PAD_MOVE;
				ST_PAD_MOVE:
				begin
					// keep the whole paddle on screen
					if (paddle_pos > x_t'(PADDLE_MAX_X))
						paddle_x <= x_t'(PADDLE_MAX_X);
					else
						paddle_x <= paddle_pos;
					state <= ST_PAD_DRAW;
				end
				ST_BALL_ERASE: if (job_done) state <= ST_SCAN;
				ST_SCAN:       if (scan_done) state <= hit ? ST_DEFLECT : ST_BALL_MOVE;
				ST_DEFLECT:    state <= ST_BALL_MOVE;
				ST_BALL_MOVE:  state <= ST_BALL_DRAW;
				ST_BALL_DRAW:  if (job_done) state <= ST_WAIT;
				default:       state <= ST_WAIT;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/pixel_arbiter.sv */
`default_nettype none

module pixel_arbiter
	import breaker_pkg::*;
(
	input  logic         clk,
	input  logic         resetn,
	input  logic [2:0]   bus_req,    // 0 has the highest priority
	output logic [2:0]   bus_gnt,
	input  pixel_t [2:0] pix,
	input  logic [2:0]   pix_valid,
	output pixel_t       pixel,
	output logic         plot
);

	always_ff @(posedge clk)
	begin
		if (!resetn)
			bus_gnt <= '0;
		else if (!(|(bus_gnt & bus_req)))   // current owner done, pick again
		begin
			if (bus_req[0])
				bus_gnt <= 3'b001;
			else if (bus_req[1])
				bus_gnt <= 3'b010;
			else if (bus_req[2])
				bus_gnt <= 3'b100;
			else
				bus_gnt <= '0;
		end
	end

	// grant is one-hot so at most one slot gets through
	always_comb
	begin
		pixel = '0;
		plot = 1'b0;
		for (int i = 0; i < 3; i++)
		begin
			if (bus_gnt[i])
			begin
				pixel = pix[i];
				plot = pix_valid[i];
			end
		end
	end

endmodule

`default_nettype wire

/* design/rect_painter.sv */
`default_nettype none

module rect_painter
	import breaker_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      job_req,
	input  rect_job_t job,
	output logic      job_ack,
	output logic      bus_req,
	input  logic      bus_gnt,
	output pixel_t    pix,
	output logic      pix_valid
);

	logic [3:0] ox, last_x;
	logic [1:0] oy, last_y;

	assign last_x = job.is_ball ? 4'(BALL_SIZE - 1) : 4'(PADDLE_W - 1);
	assign last_y = job.is_ball ? 2'(BALL_SIZE - 1) : 2'(PADDLE_H - 1);

	assign pix.x = job.x + x_t'(ox);
	assign pix.y = job.y + y_t'(oy);
	assign pix.colour = job.colour;
	assign pix_valid = bus_req && bus_gnt;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			bus_req <= 1'b0;
			job_ack <= 1'b0;
		end
		else if (job_req && !bus_req && !job_ack)
		begin
			bus_req <= 1'b1;
			ox <= '0;
			oy <= '0;
		end
		else if (pix_valid)
		begin
			if (ox == last_x)
			begin
				ox <= '0;
				oy <= oy + 1'b1;
				if (oy == last_y)
				begin
					bus_req <= 1'b0;
					job_ack <= 1'b1;
				end
			end
			else
				ox <= ox + 1'b1;
		end
		else if (!job_req)
			job_ack <= 1'b0;
	end

endmodule

`default_nettype wire

/* design/screen_wiper.sv */
`default_nettype none

module screen_wiper
	import breaker_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  logic   wipe_req,
	output logic   wipe_ack,
	output logic   bus_req,
	input  logic   bus_gnt,
	output pixel_t pix,
	output logic   pix_valid
);

	x_t wx;
	y_t wy;

	assign pix = '{x: wx, y: wy, colour: '0};
	assign pix_valid = bus_req && bus_gnt;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			bus_req <= 1'b0;
			wipe_ack <= 1'b0;
		end
		else if (wipe_req && !bus_req && !wipe_ack)
		begin
			bus_req <= 1'b1;
			wx <= '0;
			wy <= '0;
		end
		else if (pix_valid)
		begin
			if (wx == x_t'(SCREEN_W - 1))
			begin
				wx <= '0;
				wy <= wy + 1'b1;
				if (wy == y_t'(SCREEN_H - 1))   // bottom right corner
				begin
					bus_req <= 1'b0;
					wipe_ack <= 1'b1;
				end
			end
			else
				wx <= wx + 1'b1;
		end
		else if (!wipe_req)
			wipe_ack <= 1'b0;
	end

endmodule

`default_nettype wire

/* sim/breaker_sva.sv */
`default_nettype none

module breaker_sva
(
	input logic       clk,
	input logic       resetn,
	input logic       wipe_req,
	input logic       wipe_ack,
	input logic       job_req,
	input logic       job_ack,
	input logic       scan_req,
	input logic       scan_ack,
	input logic [2:0] bus_req,
	input logic [2:0] bus_gnt
);

	// req holds until its ack arrives
	wipe_req_held: assert property (@(posedge clk) disable iff (!resetn)
		wipe_req && !wipe_ack |=> wipe_req)
		else $error("wipe_req fell before wipe_ack rose");
	job_req_held: assert property (@(posedge clk) disable iff (!resetn)
		job_req && !job_ack |=> job_req)
		else $error("job_req fell before job_ack rose");
	scan_req_held: assert property (@(posedge clk) disable iff (!resetn)
		scan_req && !scan_ack |=> scan_req)
		else $error("scan_req fell before scan_ack rose");

	// ack holds while req is still high
	wipe_ack_held: assert property (@(posedge clk) disable iff (!resetn)
		wipe_ack && wipe_req |=> wipe_ack)
		else $error("wipe_ack fell while wipe_req was high");
	job_ack_held: assert property (@(posedge clk) disable iff (!resetn)
		job_ack && job_req |=> job_ack)
		else $error("job_ack fell while job_req was high");
	scan_ack_held: assert property (@(posedge clk) disable iff (!resetn)
		scan_ack && scan_req |=> scan_ack)
		else $error("scan_ack fell while scan_req was high");

	// jobs never overlap, so one painter owns or asks for the bus at a time
	one_owner: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0(bus_req | bus_gnt))
		else $error("more than one painter holds or requests the pixel bus");

endmodule

bind breaker_top breaker_sva u_sva (
	.clk(clk),
	.resetn(resetn),
	.wipe_req(wipe_req),
	.wipe_ack(wipe_ack),
	.job_req(job_req),
	.job_ack(job_ack),
	.scan_req(scan_req),
	.scan_ack(scan_ack),
	.bus_req(bus_req),
	.bus_gnt(bus_gnt)
);

`default_nettype wire

/* sim/breaker_tb.sv */
`default_nettype none

module breaker_tb
	import breaker_pkg::*;
;

	localparam int FRAME_LEN = 200;
	localparam int RUN_FRAMES = 300;
	localparam int BALL_EVENTS = 120;   // about 240 frames of play
	localparam int CYCLE_LIMIT = SCREEN_W * SCREEN_H + BRICK_COUNT * 72
		+ RUN_FRAMES * FRAME_LEN + 2000;

	logic   clk;
	logic   resetn;
	x_t     paddle_pos;
	pixel_t pixel;
	logic   plot;

	logic [31:0] lfsr;
	int          cycles = 0;
	int          draws_done = 0;    // paddle draws seen by the compare process
	int          pix_errors = 0;
	int          seq_errors = 0;
	pixel_t      held [$];          // pixels already fetched for shape detection

	// model brick table, filled from the layout rule
	int          brick_x [BRICK_COUNT];
	int          brick_y [BRICK_COUNT];
	colour_t     brick_c [BRICK_COUNT];

	breaker_top #(
		.frame_cycles(FRAME_LEN)
	) dut (
		.clk(clk),
		.resetn(resetn),
		.paddle_pos(paddle_pos),
		.pixel(pixel),
		.plot(plot)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
	endfunction

	task automatic random_byte(output x_t b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_step(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	// next ball state after one move, bounces as the game rules give them
	function automatic ball_t next_ball(input ball_t b, input x_t pad);
		ball_t n;
		int    rel;
		n = b;
		rel = int'(b.x) - int'(pad);
		if (b.dx)
			{n.x, n.dx} = (b.x == 8'd158) ? {8'd157, 1'b0} : {b.x + 8'd1, 1'b1};
		else
			{n.x, n.dx} = (b.x == 8'd0) ? {8'd1, 1'b1} : {b.x - 8'd1, 1'b0};
		if (b.dy && b.y == 7'd110 && rel >= 0 && rel <= 15)
			{n.y, n.dy} = {7'd109, 1'b0};
		else if (b.dy && b.y == 7'd117)
			{n.y, n.dy} = {7'd116, 1'b0};
		else if (b.dy)
			n.y = b.y + 7'd1;
		else if (b.y == 7'd0)
			{n.y, n.dy} = {7'd1, 1'b1};
		else
			n.y = b.y - 7'd1;
		return n;
	endfunction

	// lowest live brick whose box overlaps the 2x2 ball, -1 if none
	function automatic int find_hit(input ball_t b);
		int bx;
		int by;
		bx = int'(b.x);
		by = int'(b.y);
		for (int i = 0; i < BRICK_COUNT; i++)
		begin
			if (brick_c[i] != 3'd0 && bx + 1 >= brick_x[i] && bx <= brick_x[i] + 15
				&& by + 1 >= brick_y[i] && by <= brick_y[i] + 3)
				return i;
		end
		return -1;
	endfunction

	task automatic fetch_pixel(output pixel_t p);
		if (held.size() > 0)
			p = held.pop_front();
		else
		begin
			@(negedge clk);
			while (plot !== 1'b1)
				@(negedge clk);
			p = pixel;
		end
	endtask

	// rows top to bottom, left to right within a row
	task automatic check_rect(input int x0, input int y0, input int w, input int h,
		input colour_t c, input string what);
		pixel_t p;
		for (int r = 0; r < h; r++)
		begin
			for (int k = 0; k < w; k++)
			begin
				fetch_pixel(p);
				if (p.x != x_t'(x0 + k) || p.y != y_t'(y0 + r) || p.colour != c)
				begin
					$display("Mismatch %s pixel: got x=%h y=%h colour=%h, expected x=%h y=%h colour=%h",
						what, p.x, p.y, p.colour, x_t'(x0 + k), y_t'(y0 + r), c);
					pix_errors++;
				end
			end
		end
	endtask

	task automatic report_counts();
		$display("errors: %0d pixel mismatches, %0d sequence errors", pix_errors, seq_errors);
	endtask

	initial
	begin : drive
		int draws_seen;
		x_t b;
		draws_seen = 0;
		lfsr = 32'hed4c;
		random_byte(b);
		paddle_pos = b;
		resetn = 1'b0;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		forever
		begin
			@(posedge clk);
			if (draws_done != draws_seen)   // new position once a paddle draw is done
			begin
				random_byte(b);
				paddle_pos <= b;
				draws_seen = draws_done;
			end
		end
	end

	initial
	begin : compare
		ball_t  ball_model;
		x_t     pad_model;
		pixel_t p0;
		pixel_t p1;
		pixel_t p2;
		int     ball_events;
		int     hit_idx;
		int     hits;
		ball_model = '{x: 8'd88, y: 7'd98, dx: 1'b1, dy: 1'b0};
		pad_model = 8'd80;
		ball_events = 0;
		hits = 0;
		for (int i = 0; i < BRICK_COUNT; i++)
		begin
			brick_x[i] = 16 * (i % 10);
			brick_y[i] = 8 * (i / 10);
			brick_c[i] = colour_t'((i % 7) + 1);
		end
		wait (resetn === 1'b1);
		check_rect(0, 0, 160, 120, 3'd0, "wipe");
		for (int i = 0; i < BRICK_COUNT; i++)
			check_rect(brick_x[i], brick_y[i], 16, 4, brick_c[i], "brick");
		check_rect(80, 115, 16, 4, 3'd7, "paddle");
		draws_done++;
		while (ball_events < BALL_EVENTS)
		begin
			fetch_pixel(p0);
			fetch_pixel(p1);
			fetch_pixel(p2);
			held.push_back(p0);
			held.push_back(p1);
			held.push_back(p2);
			if (p2.y == p0.y)   // third pixel still on the first row, so a paddle
			begin
				check_rect(int'(pad_model), 115, 16, 4, 3'd0, "paddle erase");
				pad_model = (paddle_pos > 8'd144) ? 8'd144 : paddle_pos;
				check_rect(int'(pad_model), 115, 16, 4, 3'd7, "paddle");
				draws_done++;
			end
			else
			begin
				check_rect(int'(ball_model.x), int'(ball_model.y), 2, 2, 3'd0, "ball erase");
				hit_idx = find_hit(ball_model);
				if (hit_idx >= 0)
				begin
					check_rect(brick_x[hit_idx], brick_y[hit_idx], 16, 4, 3'd0, "brick erase");
					brick_c[hit_idx] = 3'd0;
					ball_model.dy = ~ball_model.dy;
					hits++;
				end
				ball_model = next_ball(ball_model, pad_model);
				check_rect(int'(ball_model.x), int'(ball_model.y), 2, 2, 3'd4, "ball");
				ball_events++;
			end
		end
		if (hits == 0)
		begin
			$display("the ball never hit a brick during the run");
			seq_errors++;
		end
		report_counts();
		if (pix_errors == 0 && seq_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the plot stream stopped after %0d cycles", cycles);
			report_counts();
			$display("TEST FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire
